//--- common/mem_pkg.sv
//********************************************************************
// sizes and micro-op format shared by the memory-execution block
// both issue queues share one depth, so LQ_DEPTH must equal SQ_DEPTH
//********************************************************************

package mem_pkg;

    localparam int XLEN = 32;
    localparam int IPR_W = 6;
    // signed word offset
    localparam int OFS_W = 8;

    localparam int DMEM_DEPTH = 64;
    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    localparam int LQ_DEPTH = 4;
    localparam int SQ_DEPTH = 4;
    // one queue module serves both
    localparam int QUE_DEPTH = (LQ_DEPTH > SQ_DEPTH) ? LQ_DEPTH : SQ_DEPTH;
    localparam int QPTR_W = $clog2(QUE_DEPTH);
    localparam int QCNT_W = $clog2(QUE_DEPTH + 1);

    localparam int BP_NUM = 2;
    localparam int DISP_NUM = 2;
    // enqueue count 0..2
    localparam int ENQ_W = 2;
    // load base, store base, store data
    localparam int RF_RD_NUM = 3;

    // load view
    typedef struct packed {
        logic             is_store;
        logic [IPR_W-1:0] iprs_base;
        logic [OFS_W-1:0] offset;
        logic [IPR_W-1:0] iprd;
    } ld_uop_t;

    // store view, low field is the data source
    typedef struct packed {
        logic             is_store;
        logic [IPR_W-1:0] iprs_base;
        logic [OFS_W-1:0] offset;
        logic [IPR_W-1:0] iprs_data;
    } st_uop_t;

    typedef union packed {
        ld_uop_t ld;
        st_uop_t st;
    } mem_uop_u;

endpackage

//--- dispatch/mem_dispatch.sv
//********************************************************************
// steers two dispatch slots in order into load and store queues
// slot 1 never accepted past a refused slot 0
//********************************************************************
`timescale 1ns/10ps

module mem_dispatch (
    input  logic [mem_pkg::DISP_NUM-1:0] i_disp_vld,
    input  mem_pkg::mem_uop_u            i_disp_uop0,
    input  mem_pkg::mem_uop_u            i_disp_uop1,
    input  logic [mem_pkg::QCNT_W-1:0]   i_lq_free,
    input  logic [mem_pkg::QCNT_W-1:0]   i_sq_free,
    output logic [mem_pkg::DISP_NUM-1:0] o_disp_rdy,
    output logic [mem_pkg::ENQ_W-1:0]    o_lq_enq_cnt,
    output mem_pkg::mem_uop_u            o_lq_enq_uop0,
    output mem_pkg::mem_uop_u            o_lq_enq_uop1,
    output logic [mem_pkg::ENQ_W-1:0]    o_sq_enq_cnt,
    output mem_pkg::mem_uop_u            o_sq_enq_uop0,
    output mem_pkg::mem_uop_u            o_sq_enq_uop1
);
    import mem_pkg::*;

    logic st0;
    logic st1;
    logic rdy0;
    logic rdy1;
    logic acc0;
    logic acc1;
    logic used1;
    logic room1;
    logic ld_take0;
    logic ld_take1;
    logic st_take0;
    logic st_take1;

    // is_store sits at the same bit in both views
    assign st0 = i_disp_uop0.st.is_store;
    assign st1 = i_disp_uop1.st.is_store;

    // slot 0 needs one free entry in its queue
    assign rdy0 = st0 ? (i_sq_free != '0) : (i_lq_free != '0);
    assign acc0 = i_disp_vld[0] && rdy0;

    // slot 0 already takes one entry when both go to the same queue
    assign used1 = acc0 && (st0 == st1);
    assign room1 = st1 ? (i_sq_free > QCNT_W'(used1)) : (i_lq_free > QCNT_W'(used1));
    // in order, stop at the first refused slot
    assign rdy1 = (!i_disp_vld[0] || rdy0) && room1;
    assign acc1 = i_disp_vld[1] && rdy1;

    assign o_disp_rdy = {rdy1, rdy0};

    assign ld_take0 = acc0 && !st0;
    assign ld_take1 = acc1 && !st1;
    assign st_take0 = acc0 && st0;
    assign st_take1 = acc1 && st1;

    assign o_lq_enq_cnt = ENQ_W'(ld_take0) + ENQ_W'(ld_take1);
    assign o_sq_enq_cnt = ENQ_W'(st_take0) + ENQ_W'(st_take1);

    // compact, older uop first
    assign o_lq_enq_uop0 = ld_take0 ? i_disp_uop0 : i_disp_uop1;
    assign o_lq_enq_uop1 = i_disp_uop1;
    assign o_sq_enq_uop0 = st_take0 ? i_disp_uop0 : i_disp_uop1;
    assign o_sq_enq_uop1 = i_disp_uop1;

endmodule

//--- logic/mem_issue_que.sv
//********************************************************************
// circular issue queue, up to two enqueues and one in-order pop
// caller keeps enqueue count within the reported free entries
//********************************************************************
`timescale 1ns/10ps

module mem_issue_que (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  logic                       i_squash_vld,
    input  logic [mem_pkg::ENQ_W-1:0]  i_enq_cnt,
    input  mem_pkg::mem_uop_u          i_enq_uop0,
    input  mem_pkg::mem_uop_u          i_enq_uop1,
    input  logic                       i_pop,
    output logic [mem_pkg::QCNT_W-1:0] o_free,
    output logic                       o_head_vld,
    output mem_pkg::mem_uop_u          o_head_uop
);
    import mem_pkg::*;

    mem_uop_u          que_mem [QUE_DEPTH];
    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QCNT_W-1:0] cnt;
    logic              do_pop;

    // a pop on an empty queue is dropped
    assign do_pop = i_pop && o_head_vld;

    // pointers and count, squash empties the queue
    always_ff @(posedge clk) begin
        if (!i_rst_n || i_squash_vld) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt <= '0;
        end else begin
            wr_ptr <= wr_ptr + QPTR_W'(i_enq_cnt);
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            cnt <= cnt + QCNT_W'(i_enq_cnt) - QCNT_W'(do_pop);
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (i_enq_cnt != '0) begin
            que_mem[wr_ptr] <= i_enq_uop0;
        end
        // second write lands on the next slot, wraps
        if (i_enq_cnt == ENQ_W'(2)) begin
            que_mem[wr_ptr + 1'b1] <= i_enq_uop1;
        end
    end

    assign o_free = QCNT_W'(QUE_DEPTH) - cnt;
    assign o_head_vld = (cnt != '0);
    assign o_head_uop = que_mem[rd_ptr];

endmodule

//--- logic/bypass_sel.sv
//********************************************************************
// operand pick from the bypass bus, else register-file data
// lowest-index valid match wins
//********************************************************************
`timescale 1ns/10ps

module bypass_sel (
    input  logic [mem_pkg::BP_NUM-1:0] i_bp_vld,
    input  logic [mem_pkg::IPR_W-1:0]  i_bp_iprd [mem_pkg::BP_NUM],
    input  logic [mem_pkg::XLEN-1:0]   i_bp_data [mem_pkg::BP_NUM],
    input  logic [mem_pkg::IPR_W-1:0]  i_target_idx,
    input  logic [mem_pkg::XLEN-1:0]   i_rf_data,
    output logic [mem_pkg::XLEN-1:0]   o_data
);
    import mem_pkg::*;

    // scan high to low so the lowest match is written last
    always_comb begin
        o_data = i_rf_data;
        for (int i = BP_NUM - 1; i >= 0; i--) begin
            if (i_bp_vld[i] && (i_bp_iprd[i] == i_target_idx)) begin
                o_data = i_bp_data[i];
            end
        end
    end

endmodule

//--- logic/load_unit.sv
//********************************************************************
// load pipe: s0 pop and rf read, s1 address and request, s2 writeback
// writeback has no back-pressure
//********************************************************************
`timescale 1ns/10ps

module load_unit (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic                        i_squash_vld,
    input  logic                        i_head_vld,
    input  mem_pkg::mem_uop_u           i_head_uop,
    input  logic [mem_pkg::XLEN-1:0]    i_rf_data,
    input  logic [mem_pkg::BP_NUM-1:0]  i_bp_vld,
    input  logic [mem_pkg::IPR_W-1:0]   i_bp_iprd [mem_pkg::BP_NUM],
    input  logic [mem_pkg::XLEN-1:0]    i_bp_data [mem_pkg::BP_NUM],
    input  logic                        i_gnt,
    input  logic [mem_pkg::XLEN-1:0]    i_mem_rdata,
    output logic                        o_pop,
    output logic [mem_pkg::IPR_W-1:0]   o_rf_idx,
    output logic                        o_req,
    output logic [mem_pkg::DMEM_AW-1:0] o_addr,
    output logic                        o_wb_vld,
    output logic [mem_pkg::IPR_W-1:0]   o_wb_iprd,
    output logic [mem_pkg::XLEN-1:0]    o_wb_data
);
    import mem_pkg::*;

    logic             s1_vld;
    logic [IPR_W-1:0] s1_iprd;
    logic [OFS_W-1:0] s1_ofs;
    logic [IPR_W-1:0] s1_base_idx;
    logic             s1_hold;
    logic [XLEN-1:0]  base_val;
    logic             s2_vld;
    logic [IPR_W-1:0] s2_iprd;

    // s1 lost arbitration, stays put
    assign s1_hold = s1_vld && !i_gnt;
    assign o_pop = i_head_vld && !s1_hold;

    // held op re-reads its base so rf data lines up next cycle
    assign o_rf_idx = s1_hold ? s1_base_idx : i_head_uop.ld.iprs_base;

    bypass_sel u_base_sel (
        .i_bp_vld     (i_bp_vld),
        .i_bp_iprd    (i_bp_iprd),
        .i_bp_data    (i_bp_data),
        .i_target_idx (s1_base_idx),
        .i_rf_data    (i_rf_data),
        .o_data       (base_val)
    );

    // word address, upper offset bits drop out mod DMEM_DEPTH
    assign o_addr = base_val[DMEM_AW-1:0] + s1_ofs[DMEM_AW-1:0];
    assign o_req = s1_vld;

    // s1 valid
    always_ff @(posedge clk) begin
        if (!i_rst_n || i_squash_vld) begin
            s1_vld <= 1'b0;
        end else if (o_pop) begin
            s1_vld <= 1'b1;
        end else if (i_gnt) begin
            s1_vld <= 1'b0;
        end
    end

    // s1 payload
    always_ff @(posedge clk) begin
        if (o_pop) begin
            s1_iprd <= i_head_uop.ld.iprd;
            s1_ofs <= i_head_uop.ld.offset;
            s1_base_idx <= i_head_uop.ld.iprs_base;
        end
    end

    // s2, read data arrives from memory this cycle
    always_ff @(posedge clk) begin
        if (!i_rst_n || i_squash_vld) begin
            s2_vld <= 1'b0;
        end else begin
            s2_vld <= s1_vld && i_gnt;
        end
    end

    always_ff @(posedge clk) begin
        s2_iprd <= s1_iprd;
    end

    assign o_wb_vld = s2_vld;
    assign o_wb_iprd = s2_iprd;
    assign o_wb_data = i_mem_rdata;

endmodule

//--- logic/store_unit.sv
//********************************************************************
// store pipe: s0 pop and rf read, s1 address, data and write request
// write happens at the granting edge, no ordering against loads
//********************************************************************
`timescale 1ns/10ps

module store_unit (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic                        i_squash_vld,
    input  logic                        i_head_vld,
    input  mem_pkg::mem_uop_u           i_head_uop,
    input  logic [mem_pkg::XLEN-1:0]    i_rf_base,
    input  logic [mem_pkg::XLEN-1:0]    i_rf_wdata,
    input  logic [mem_pkg::BP_NUM-1:0]  i_bp_vld,
    input  logic [mem_pkg::IPR_W-1:0]   i_bp_iprd [mem_pkg::BP_NUM],
    input  logic [mem_pkg::XLEN-1:0]    i_bp_data [mem_pkg::BP_NUM],
    input  logic                        i_gnt,
    output logic                        o_pop,
    output logic [mem_pkg::IPR_W-1:0]   o_rf_base_idx,
    output logic [mem_pkg::IPR_W-1:0]   o_rf_data_idx,
    output logic                        o_req,
    output logic [mem_pkg::DMEM_AW-1:0] o_addr,
    output logic [mem_pkg::XLEN-1:0]    o_wdata
);
    import mem_pkg::*;

    logic             s1_vld;
    logic [OFS_W-1:0] s1_ofs;
    logic [IPR_W-1:0] s1_base_idx;
    logic [IPR_W-1:0] s1_data_idx;
    logic             s1_hold;
    logic [XLEN-1:0]  base_val;

    assign s1_hold = s1_vld && !i_gnt;
    assign o_pop = i_head_vld && !s1_hold;

    // both operands re-read while s1 waits for the port
    assign o_rf_base_idx = s1_hold ? s1_base_idx : i_head_uop.st.iprs_base;
    assign o_rf_data_idx = s1_hold ? s1_data_idx : i_head_uop.st.iprs_data;

    bypass_sel u_base_sel (
        .i_bp_vld     (i_bp_vld),
        .i_bp_iprd    (i_bp_iprd),
        .i_bp_data    (i_bp_data),
        .i_target_idx (s1_base_idx),
        .i_rf_data    (i_rf_base),
        .o_data       (base_val)
    );

    bypass_sel u_data_sel (
        .i_bp_vld     (i_bp_vld),
        .i_bp_iprd    (i_bp_iprd),
        .i_bp_data    (i_bp_data),
        .i_target_idx (s1_data_idx),
        .i_rf_data    (i_rf_wdata),
        .o_data       (o_wdata)
    );

    assign o_addr = base_val[DMEM_AW-1:0] + s1_ofs[DMEM_AW-1:0];
    assign o_req = s1_vld;

    always_ff @(posedge clk) begin
        if (!i_rst_n || i_squash_vld) begin
            s1_vld <= 1'b0;
        end else if (o_pop) begin
            s1_vld <= 1'b1;
        end else if (i_gnt) begin
            s1_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (o_pop) begin
            s1_ofs <= i_head_uop.st.offset;
            s1_base_idx <= i_head_uop.st.iprs_base;
            s1_data_idx <= i_head_uop.st.iprs_data;
        end
    end

endmodule

//--- logic/dmem_arbiter.sv
//********************************************************************
// round-robin arbiter for the single data memory port
// grant is combinational, load wins the first tie after reset
//********************************************************************
`timescale 1ns/10ps

module dmem_arbiter (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic                        i_ld_req,
    input  logic [mem_pkg::DMEM_AW-1:0] i_ld_addr,
    input  logic                        i_st_req,
    input  logic [mem_pkg::DMEM_AW-1:0] i_st_addr,
    input  logic [mem_pkg::XLEN-1:0]    i_st_wdata,
    output logic                        o_ld_gnt,
    output logic                        o_st_gnt,
    output logic                        o_mem_en,
    output logic                        o_mem_we,
    output logic [mem_pkg::DMEM_AW-1:0] o_mem_addr,
    output logic [mem_pkg::XLEN-1:0]    o_mem_wdata
);

    // last winner was the load unit
    logic last_ld;

    // on a tie the side that lost last time goes
    assign o_ld_gnt = i_ld_req && (!i_st_req || !last_ld);
    assign o_st_gnt = i_st_req && !o_ld_gnt;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            last_ld <= 1'b0;
        end else if (o_ld_gnt) begin
            last_ld <= 1'b1;
        end else if (o_st_gnt) begin
            last_ld <= 1'b0;
        end
    end

    // winner onto the port
    assign o_mem_en = o_ld_gnt || o_st_gnt;
    assign o_mem_we = o_st_gnt;
    assign o_mem_addr = o_st_gnt ? i_st_addr : i_ld_addr;
    assign o_mem_wdata = i_st_wdata;

endmodule

//--- logic/data_mem.sv
//********************************************************************
// single-port word memory, read data one cycle after the request
// contents are not cleared by reset
//********************************************************************
`timescale 1ns/10ps

module data_mem (
    input  logic                        clk,
    input  logic                        i_en,
    input  logic                        i_we,
    input  logic [mem_pkg::DMEM_AW-1:0] i_addr,
    input  logic [mem_pkg::XLEN-1:0]    i_wdata,
    output logic [mem_pkg::XLEN-1:0]    o_rdata
);
    import mem_pkg::*;

    logic [XLEN-1:0] mem [DMEM_DEPTH];

    // rdata holds its value on writes and idle cycles
    always_ff @(posedge clk) begin
        if (i_en) begin
            if (i_we) begin
                mem[i_addr] <= i_wdata;
            end else begin
                o_rdata <= mem[i_addr];
            end
        end
    end

endmodule

//--- logic/mem_block.sv
//********************************************************************
// memory-execution block top, one load and one store per cycle
// rf index 0 load base, 1 store base, 2 store data
//********************************************************************
`timescale 1ns/10ps

module mem_block (
    input  logic                         clk,
    input  logic                         i_rst_n,
    input  logic                         i_squash_vld,
    input  logic [mem_pkg::DISP_NUM-1:0] i_disp_vld,
    input  mem_pkg::mem_uop_u            i_disp_uop0,
    input  mem_pkg::mem_uop_u            i_disp_uop1,
    output logic [mem_pkg::DISP_NUM-1:0] o_disp_rdy,
    output logic [mem_pkg::IPR_W-1:0]    o_rf_idx [mem_pkg::RF_RD_NUM],
    input  logic [mem_pkg::XLEN-1:0]     i_rf_data [mem_pkg::RF_RD_NUM],
    input  logic [mem_pkg::BP_NUM-1:0]   i_bp_vld,
    input  logic [mem_pkg::IPR_W-1:0]    i_bp_iprd [mem_pkg::BP_NUM],
    input  logic [mem_pkg::XLEN-1:0]     i_bp_data [mem_pkg::BP_NUM],
    output logic                         o_wb_vld,
    output logic [mem_pkg::IPR_W-1:0]    o_wb_iprd,
    output logic [mem_pkg::XLEN-1:0]     o_wb_data
);
    import mem_pkg::*;

    // dispatch to queues
    logic [ENQ_W-1:0]   lq_enq_cnt;
    logic [ENQ_W-1:0]   sq_enq_cnt;
    mem_uop_u           lq_enq_uop0;
    mem_uop_u           lq_enq_uop1;
    mem_uop_u           sq_enq_uop0;
    mem_uop_u           sq_enq_uop1;
    logic [QCNT_W-1:0]  lq_free;
    logic [QCNT_W-1:0]  sq_free;
    // queue heads
    logic               lq_head_vld;
    logic               sq_head_vld;
    mem_uop_u           lq_head_uop;
    mem_uop_u           sq_head_uop;
    logic               ld_pop;
    logic               st_pop;
    // units to arbiter
    logic               ld_req;
    logic               st_req;
    logic               ld_gnt;
    logic               st_gnt;
    logic [DMEM_AW-1:0] ld_addr;
    logic [DMEM_AW-1:0] st_addr;
    logic [XLEN-1:0]    st_wdata;
    // memory port
    logic               mem_en;
    logic               mem_we;
    logic [DMEM_AW-1:0] mem_addr;
    logic [XLEN-1:0]    mem_wdata;
    logic [XLEN-1:0]    mem_rdata;

    mem_dispatch u_dispatch (
        .i_disp_vld    (i_disp_vld),
        .i_disp_uop0   (i_disp_uop0),
        .i_disp_uop1   (i_disp_uop1),
        .i_lq_free     (lq_free),
        .i_sq_free     (sq_free),
        .o_disp_rdy    (o_disp_rdy),
        .o_lq_enq_cnt  (lq_enq_cnt),
        .o_lq_enq_uop0 (lq_enq_uop0),
        .o_lq_enq_uop1 (lq_enq_uop1),
        .o_sq_enq_cnt  (sq_enq_cnt),
        .o_sq_enq_uop0 (sq_enq_uop0),
        .o_sq_enq_uop1 (sq_enq_uop1)
    );

    mem_issue_que u_lq (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_squash_vld (i_squash_vld),
        .i_enq_cnt    (lq_enq_cnt),
        .i_enq_uop0   (lq_enq_uop0),
        .i_enq_uop1   (lq_enq_uop1),
        .i_pop        (ld_pop),
        .o_free       (lq_free),
        .o_head_vld   (lq_head_vld),
        .o_head_uop   (lq_head_uop)
    );

    mem_issue_que u_sq (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_squash_vld (i_squash_vld),
        .i_enq_cnt    (sq_enq_cnt),
        .i_enq_uop0   (sq_enq_uop0),
        .i_enq_uop1   (sq_enq_uop1),
        .i_pop        (st_pop),
        .o_free       (sq_free),
        .o_head_vld   (sq_head_vld),
        .o_head_uop   (sq_head_uop)
    );

    load_unit u_ldu (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_squash_vld (i_squash_vld),
        .i_head_vld   (lq_head_vld),
        .i_head_uop   (lq_head_uop),
        .i_rf_data    (i_rf_data[0]),
        .i_bp_vld     (i_bp_vld),
        .i_bp_iprd    (i_bp_iprd),
        .i_bp_data    (i_bp_data),
        .i_gnt        (ld_gnt),
        .i_mem_rdata  (mem_rdata),
        .o_pop        (ld_pop),
        .o_rf_idx     (o_rf_idx[0]),
        .o_req        (ld_req),
        .o_addr       (ld_addr),
        .o_wb_vld     (o_wb_vld),
        .o_wb_iprd    (o_wb_iprd),
        .o_wb_data    (o_wb_data)
    );

    store_unit u_stu (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_squash_vld  (i_squash_vld),
        .i_head_vld    (sq_head_vld),
        .i_head_uop    (sq_head_uop),
        .i_rf_base     (i_rf_data[1]),
        .i_rf_wdata    (i_rf_data[2]),
        .i_bp_vld      (i_bp_vld),
        .i_bp_iprd     (i_bp_iprd),
        .i_bp_data     (i_bp_data),
        .i_gnt         (st_gnt),
        .o_pop         (st_pop),
        .o_rf_base_idx (o_rf_idx[1]),
        .o_rf_data_idx (o_rf_idx[2]),
        .o_req         (st_req),
        .o_addr        (st_addr),
        .o_wdata       (st_wdata)
    );

    dmem_arbiter u_arb (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_ld_req    (ld_req),
        .i_ld_addr   (ld_addr),
        .i_st_req    (st_req),
        .i_st_addr   (st_addr),
        .i_st_wdata  (st_wdata),
        .o_ld_gnt    (ld_gnt),
        .o_st_gnt    (st_gnt),
        .o_mem_en    (mem_en),
        .o_mem_we    (mem_we),
        .o_mem_addr  (mem_addr),
        .o_mem_wdata (mem_wdata)
    );

    data_mem u_dmem (
        .clk     (clk),
        .i_en    (mem_en),
        .i_we    (mem_we),
        .i_addr  (mem_addr),
        .i_wdata (mem_wdata),
        .o_rdata (mem_rdata)
    );

endmodule

//--- sim/tb_mem_block.sv
//********************************************************************
// table-driven testbench for mem_block, rf model answers one cycle late
// loads only read words that an earlier, drained store has written
//********************************************************************
`timescale 1ns/10ps

module tb_mem_block;
    import mem_pkg::*;

    // one stimulus row, bypass entry 0 only
    typedef struct packed {
        logic [DISP_NUM-1:0] vld;
        mem_uop_u            uop0;
        mem_uop_u            uop1;
        logic [DISP_NUM-1:0] exp_rdy;
        logic                squash;
        logic                drain;
        logic                bp_vld;
        logic [IPR_W-1:0]    bp_iprd;
        logic [XLEN-1:0]     bp_data;
    } row_t;

    // base and data registers used by the table
    localparam logic [IPR_W-1:0] B1 = 6'd5;
    localparam logic [IPR_W-1:0] B2 = 6'd9;
    localparam logic [IPR_W-1:0] B3 = 6'd20;
    localparam logic [IPR_W-1:0] D1 = 6'd33;
    localparam logic [IPR_W-1:0] D2 = 6'd40;
    localparam logic [IPR_W-1:0] D3 = 6'd50;

    logic                clk;
    logic                rst_n;
    logic                squash_vld;
    logic [DISP_NUM-1:0] disp_vld;
    mem_uop_u            disp_uop0;
    mem_uop_u            disp_uop1;
    logic [DISP_NUM-1:0] disp_rdy;
    logic [IPR_W-1:0]    rf_idx [RF_RD_NUM];
    logic [IPR_W-1:0]    rf_idx_q [RF_RD_NUM];
    logic [XLEN-1:0]     rf_data [RF_RD_NUM];
    logic [BP_NUM-1:0]   bp_vld;
    logic [IPR_W-1:0]    bp_iprd [BP_NUM];
    logic [XLEN-1:0]     bp_data [BP_NUM];
    logic                wb_vld;
    logic [IPR_W-1:0]    wb_iprd;
    logic [XLEN-1:0]     wb_data;

    // register-file contents and memory model
    logic [XLEN-1:0]     rf_mem [1 << IPR_W];
    logic [XLEN-1:0]     mem_model [DMEM_DEPTH];
    logic                mem_written [DMEM_DEPTH];
    row_t                rows [$];
    // expected writebacks in load order
    logic [IPR_W-1:0]    sb_iprd [$];
    logic [XLEN-1:0]     sb_data [$];
    integer              seed;

    mem_block mem_block_i (
        .clk          (clk),
        .i_rst_n      (rst_n),
        .i_squash_vld (squash_vld),
        .i_disp_vld   (disp_vld),
        .i_disp_uop0  (disp_uop0),
        .i_disp_uop1  (disp_uop1),
        .o_disp_rdy   (disp_rdy),
        .o_rf_idx     (rf_idx),
        .i_rf_data    (rf_data),
        .i_bp_vld     (bp_vld),
        .i_bp_iprd    (bp_iprd),
        .i_bp_data    (bp_data),
        .o_wb_vld     (wb_vld),
        .o_wb_iprd    (wb_iprd),
        .o_wb_data    (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // rf read, index seen mid-cycle, data out after the next edge
    always @(negedge clk) begin
        for (int k = 0; k < RF_RD_NUM; k++) begin
            rf_idx_q[k] = rf_idx[k];
        end
    end

    always @(posedge clk) begin
        #1;
        for (int k = 0; k < RF_RD_NUM; k++) begin
            rf_data[k] = rf_mem[rf_idx_q[k]];
        end
    end

    task automatic report_fail();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // base plus sign-extended offset, wraps at 64 words
    function automatic logic [DMEM_AW-1:0] word_addr(logic [XLEN-1:0] base_val,
                                                     logic [OFS_W-1:0] ofs);
        logic [XLEN-1:0] sum;
        sum = base_val + {{(XLEN-OFS_W){ofs[OFS_W-1]}}, ofs};
        return sum[DMEM_AW-1:0];
    endfunction

    function automatic mem_uop_u make_load(logic [IPR_W-1:0] base, logic [OFS_W-1:0] ofs,
                                           logic [IPR_W-1:0] iprd);
        mem_uop_u u;
        u.ld.is_store = 1'b0;
        u.ld.iprs_base = base;
        u.ld.offset = ofs;
        u.ld.iprd = iprd;
        return u;
    endfunction

    function automatic mem_uop_u make_store(logic [IPR_W-1:0] base, logic [OFS_W-1:0] ofs,
                                            logic [IPR_W-1:0] src);
        mem_uop_u u;
        u.st.is_store = 1'b1;
        u.st.iprs_base = base;
        u.st.offset = ofs;
        u.st.iprs_data = src;
        return u;
    endfunction

    task automatic add_row(input logic [1:0] vld, input mem_uop_u u0, input mem_uop_u u1,
                           input logic [1:0] exp_rdy, input logic squash, input logic drain,
                           input logic bpv, input logic [IPR_W-1:0] bpi,
                           input logic [XLEN-1:0] bpd);
        row_t row;
        row.vld = vld;
        row.uop0 = u0;
        row.uop1 = u1;
        row.exp_rdy = exp_rdy;
        row.squash = squash;
        row.drain = drain;
        row.bp_vld = bpv;
        row.bp_iprd = bpi;
        row.bp_data = bpd;
        rows.push_back(row);
    endtask

    task automatic add_idle(input int n, input logic drain);
        for (int i = 0; i < n; i++) begin
            add_row(2'b00, '0, '0, 2'b00, 1'b0, drain, 1'b0, '0, '0);
        end
    endtask

    task automatic build_table();
        logic [OFS_W-1:0]   o1;
        logic [OFS_W-1:0]   o2;
        logic [DMEM_AW-1:0] a3;
        logic [XLEN-1:0]    v;
        o1 = 8'($random(seed));
        o2 = 8'($random(seed));
        a3 = word_addr(rf_mem[B3], o2);
        // bypass value lands on the word stored through B3
        v = (32'h5a5a_5a40 & 32'hffff_ffc0) | {26'd0, a3};
        add_idle(2, 1'b0);
        // stores, then drain, then read them back
        add_row(2'b11, make_store(B1, o1, D1), make_store(B2, o1, D2), 2'b11, 0, 0, 0, '0, '0);
        add_row(2'b01, make_store(B3, o2, D3), '0, 2'b01, 0, 0, 0, '0, '0);
        add_idle(4, 1'b0);
        add_idle(1, 1'b1);
        add_row(2'b11, make_load(B1, o1, 6'd7), make_load(B3, o2, 6'd8), 2'b11, 0, 0, 0, '0, '0);
        add_idle(1, 1'b1);
        // load and store in one row, store overwrites the B1 word
        add_row(2'b11, make_load(B2, o1, 6'd10), make_store(B1, o1, D3), 2'b11,
                0, 0, 0, '0, '0);
        add_idle(4, 1'b0);
        add_idle(1, 1'b1);
        add_row(2'b01, make_load(B1, o1, 6'd11), '0, 2'b01, 0, 0, 0, '0, '0);
        add_idle(1, 1'b1);
        // fill the load queue, pop rate one per cycle until a store wins a tie
        add_row(2'b11, make_load(B1, o1, 6'd16), make_load(B2, o1, 6'd17), 2'b11,
                0, 0, 0, '0, '0);
        add_row(2'b11, make_load(B3, o2, 6'd18), make_load(B1, o1, 6'd19), 2'b11,
                0, 0, 0, '0, '0);
        // store rewrites the value the B1 word already holds
        add_row(2'b11, make_load(B2, o1, 6'd20), make_store(B1, o1, D3), 2'b11,
                0, 0, 0, '0, '0);
        add_row(2'b11, make_load(B3, o2, 6'd21), make_load(B1, o1, 6'd22), 2'b01,
                0, 0, 0, '0, '0);
        // load s1 loses to the store here, no pop
        add_row(2'b11, make_load(B2, o1, 6'd23), make_load(B3, o2, 6'd27), 2'b01,
                0, 0, 0, '0, '0);
        // queue full, refused load also blocks the store behind it
        add_row(2'b11, make_load(B1, o1, 6'd28), make_store(B1, o1, D3), 2'b00,
                0, 0, 0, '0, '0);
        add_idle(1, 1'b1);
        // bypass hits the base two rows later, in s1
        add_row(2'b01, make_load(B2, 8'h00, 6'd12), '0, 2'b01, 0, 0, 0, '0, '0);
        add_idle(1, 1'b0);
        add_row(2'b00, '0, '0, 2'b00, 0, 0, 1'b1, B2, v);
        add_idle(1, 1'b1);
        // squash kills both queued loads
        add_row(2'b11, make_load(B1, o1, 6'd24), make_load(B2, o1, 6'd25), 2'b11,
                0, 0, 0, '0, '0);
        add_row(2'b00, '0, '0, 2'b00, 1'b1, 0, 0, '0, '0);
        add_row(2'b01, make_load(B3, o2, 6'd26), '0, 2'b01, 0, 0, 0, '0, '0);
        add_idle(1, 1'b1);
    endtask

    // update memory model or push the expected load result
    task automatic accept_uop(input int r, input mem_uop_u u);
        logic [XLEN-1:0]    base_val;
        logic [DMEM_AW-1:0] addr;
        base_val = rf_mem[u.ld.iprs_base];
        if (r + 2 < rows.size() && rows[r+2].bp_vld && rows[r+2].bp_iprd == u.ld.iprs_base) begin
            base_val = rows[r+2].bp_data;
        end
        addr = word_addr(base_val, u.ld.offset);
        if (u.st.is_store) begin
            mem_model[addr] = rf_mem[u.st.iprs_data];
            mem_written[addr] = 1'b1;
        end else begin
            assert (mem_written[addr]) else begin
                $display("load reads word %0h that no store has written", addr);
                report_fail();
            end
            sb_iprd.push_back(u.ld.iprd);
            sb_data.push_back(mem_model[addr]);
        end
    endtask

    task automatic wait_drain();
        int cyc;
        cyc = 0;
        while (sb_iprd.size() != 0 && cyc < 50) begin
            @(posedge clk);
            cyc++;
        end
        assert (sb_iprd.size() == 0) else begin
            $display("timeout, %0d load writebacks missing after 50 cycles", sb_iprd.size());
            report_fail();
        end
    endtask

    // writeback monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && wb_vld) begin
            assert (sb_iprd.size() != 0) else begin
                $display("writeback with no load outstanding, iprd %0h", wb_iprd);
                report_fail();
            end
            assert (wb_iprd == sb_iprd[0]) else begin
                $display("MISMATCH o_wb_iprd exp %h got %h", sb_iprd[0], wb_iprd);
                report_fail();
            end
            assert (wb_data == sb_data[0]) else begin
                $display("MISMATCH o_wb_data exp %h got %h", sb_data[0], wb_data);
                report_fail();
            end
            void'(sb_iprd.pop_front());
            void'(sb_data.pop_front());
        end
    end

    initial begin
        seed = 69205;
        rst_n = 1'b0;
        squash_vld = 1'b0;
        disp_vld = '0;
        disp_uop0 = '0;
        disp_uop1 = '0;
        bp_vld = '0;
        for (int i = 0; i < BP_NUM; i++) begin
            bp_iprd[i] = '0;
            bp_data[i] = '0;
        end
        for (int i = 0; i < RF_RD_NUM; i++) begin
            rf_data[i] = '0;
        end
        for (int i = 0; i < (1 << IPR_W); i++) begin
            rf_mem[i] = i * 32'h0101_0101 + 32'd3;
        end
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            mem_written[i] = 1'b0;
        end
        build_table();
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int r = 0; r < rows.size(); r++) begin
            @(posedge clk);
            #1;
            disp_vld = rows[r].vld;
            disp_uop0 = rows[r].uop0;
            disp_uop1 = rows[r].uop1;
            squash_vld = rows[r].squash;
            bp_vld = {1'b0, rows[r].bp_vld};
            bp_iprd[0] = rows[r].bp_iprd;
            bp_data[0] = rows[r].bp_data;
            #1;
            // only valid slots carry a ready expectation
            assert ((disp_rdy & rows[r].vld) == rows[r].exp_rdy) else begin
                $display("MISMATCH o_disp_rdy exp %h got %h", rows[r].exp_rdy,
                         disp_rdy & rows[r].vld);
                report_fail();
            end
            if (rows[r].squash) begin
                sb_iprd.delete();
                sb_data.delete();
            end
            if (rows[r].vld[0] && rows[r].exp_rdy[0]) begin
                accept_uop(r, rows[r].uop0);
            end
            if (rows[r].vld[1] && rows[r].exp_rdy[1]) begin
                accept_uop(r, rows[r].uop1);
            end
            if (rows[r].drain) begin
                wait_drain();
            end
        end
        @(posedge clk);
        #1;
        disp_vld = '0;
        squash_vld = 1'b0;
        bp_vld = '0;
        wait_drain();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- flist.f
common/mem_pkg.sv
dispatch/mem_dispatch.sv
logic/mem_issue_que.sv
logic/bypass_sel.sv
logic/load_unit.sv
logic/store_unit.sv
logic/dmem_arbiter.sv
logic/data_mem.sv
logic/mem_block.sv
sim/tb_mem_block.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_block
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
